//--- rv_core.f
core_pkg.sv
reg_file.sv
fetch_unit.sv
decode_unit.sv
exec_unit.sv
load_store_unit.sv
mem_arbiter.sv
rv_core.sv
tb_clock_gen.sv
tb_memory.sv
rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - core_pkg.sv
  - reg_file.sv
  - fetch_unit.sv
  - decode_unit.sv
  - exec_unit.sv
  - load_store_unit.sv
  - mem_arbiter.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_memory.sv
      - rv_core_tb.sv

//--- rv_core_tb.sv
`default_nettype none

module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import core_pkg::*;

  localparam word_t KWORD = 32'h8a7f_c3e1;

  logic       clk;
  logic       rst_n_gen;
  logic       run_rst_n;
  logic       rst_n_dut;
  logic       rst_q;
  logic       first_seen;
  logic       run_one;
  logic       mem_req;
  logic       mem_we;
  word_t      mem_addr;
  word_t      mem_wdata;
  logic [3:0] mem_wstrb;
  logic       mem_ack;
  word_t      mem_rdata;
  logic       mem_err;
  logic       halted;
  logic       fault;
  int         seed;
  int         pc_w;
  int         res_off;
  word_t      op_a;
  word_t      op_b;
  word_t      exp_addr [$];
  logic [3:0] exp_strb [$];
  word_t      exp_data [$];

  assign rst_n_dut = rst_n_gen & run_rst_n;

  tb_clock_gen clk_i (.clk(clk), .rst_n(rst_n_gen));

  tb_memory mem_i (
    .clk(clk), .rst_n(rst_n_dut), .req(mem_req), .we(mem_we), .addr(mem_addr),
    .wdata(mem_wdata), .wstrb(mem_wstrb), .ack(mem_ack), .rdata(mem_rdata), .err(mem_err)
  );

  rv_core #(.RESET_PC(32'h0)) dut_i (
    .clk(clk), .rst_n(rst_n_dut), .mem_req(mem_req), .mem_we(mem_we),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .mem_err(mem_err),
    .halted(halted), .fault(fault)
  );

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // instruction encoders
  function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                  input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
  endfunction

  function automatic word_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                  input int rd, input opcode_t opc);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic word_t enc_s(input int imm, input int rs2, input int rs1,
                                  input logic [2:0] f3);
    logic [11:0] i;
    i = 12'(imm);
    return {i[11:5], 5'(rs2), 5'(rs1), f3, i[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(input int imm, input int rs2, input int rs1,
                                  input logic [2:0] f3);
    logic [12:0] i;
    i = 13'(imm);
    return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_j(input int imm, input int rd);
    logic [20:0] i;
    i = 21'(imm);
    return {i[20], i[10:1], i[11], i[19:12], 5'(rd), OPC_JAL};
  endfunction

  // lane select and sign or zero extension per RV32I
  function automatic word_t ext_load(input word_t w, input int off, input int size,
                                     input logic uns);
    word_t s;
    s = w >> (8 * off);
    if (size == 0) begin
      return uns ? {24'b0, s[7:0]} : {{24{s[7]}}, s[7:0]};
    end else if (size == 1) begin
      return uns ? {16'b0, s[15:0]} : {{16{s[15]}}, s[15:0]};
    end
    return s;
  endfunction

  function automatic word_t strb_mask(input logic [3:0] s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  task automatic emit(input word_t w);
    mem_i.mem[pc_w >> 2] = w;
    pc_w += 4;
  endtask

  task automatic expect_store(input word_t a, input logic [3:0] s, input word_t d);
    exp_addr.push_back(a);
    exp_strb.push_back(s);
    exp_data.push_back(d);
  endtask

  // sw rs into the next result slot above x4 = 0x900
  task automatic store_result(input int rs, input word_t val);
    emit(enc_s(res_off, rs, 4, 3'b010));
    expect_store(32'h900 + res_off, 4'hf, val);
    res_off += 4;
  endtask

  task automatic r_op(input logic [6:0] f7, input logic [2:0] f3, input word_t val);
    emit(enc_r(f7, 3, 2, f3, 5));
    store_result(5, val);
  endtask

  task automatic i_op(input int imm, input logic [2:0] f3, input word_t val);
    emit(enc_i(imm, 2, f3, 5, OPC_OP_IMM));
    store_result(5, val);
  endtask

  task automatic load_back(input logic [2:0] f3, input int off);
    emit(enc_i(8 + off, 1, f3, 11, OPC_LOAD));
    store_result(11, ext_load(KWORD, off, f3[1:0], f3[2]));
  endtask

  task automatic fill_memory();
    for (int i = 0; i < 1024; i++) begin
      mem_i.mem[i] = 32'h9e37_79b9 * (i + 1);
    end
    mem_i.mem[32'h800 >> 2] = op_a;
    mem_i.mem[32'h804 >> 2] = op_b;
    mem_i.mem[32'h808 >> 2] = KWORD;
    pc_w    = 0;
    res_off = 0;
  endtask

  task automatic build_main_program();
    int p;
    // x1 = 0x800, x2/x3 operands, x4 = 0x900
    emit(enc_i(1, 0, 3'b000, 1, OPC_OP_IMM));
    emit(enc_i(11, 1, 3'b001, 1, OPC_OP_IMM));
    emit(enc_i(0, 1, 3'b010, 2, OPC_LOAD));
    emit(enc_i(4, 1, 3'b010, 3, OPC_LOAD));
    emit(enc_i(256, 1, 3'b000, 4, OPC_OP_IMM));
    r_op(7'h00, 3'b000, op_a + op_b);
    r_op(7'h20, 3'b000, op_a - op_b);
    r_op(7'h00, 3'b100, op_a ^ op_b);
    r_op(7'h00, 3'b110, op_a | op_b);
    r_op(7'h00, 3'b111, op_a & op_b);
    r_op(7'h00, 3'b001, op_a << op_b[4:0]);
    r_op(7'h00, 3'b101, op_a >> op_b[4:0]);
    r_op(7'h20, 3'b101, word_t'($signed(op_a) >>> op_b[4:0]));
    r_op(7'h00, 3'b010, {31'b0, $signed(op_a) < $signed(op_b)});
    r_op(7'h00, 3'b011, {31'b0, op_a < op_b});
    i_op(-291, 3'b000, op_a + 32'hffff_fedd);
    i_op(12'h5a5, 3'b100, op_a ^ 32'h5a5);
    i_op(-16, 3'b110, op_a | 32'hffff_fff0);
    i_op(12'h03c, 3'b111, op_a & 32'h3c);
    i_op(-5, 3'b010, {31'b0, $signed(op_a) < -5});
    i_op(-5, 3'b011, {31'b0, op_a < 32'hffff_fffb});
    i_op(7, 3'b001, op_a << 7);
    i_op(13, 3'b101, op_a >> 13);
    i_op(12'h40d, 3'b101, word_t'($signed(op_a) >>> 13));
    emit({20'habcde, 5'd5, OPC_LUI});
    store_result(5, 32'habcd_e000);
    p = pc_w;
    emit({20'h00012, 5'd5, OPC_AUIPC});
    store_result(5, p + 32'h12000);
    // sub-word loads of the known word at 0x808
    load_back(3'b000, 0);
    load_back(3'b000, 1);
    load_back(3'b100, 2);
    load_back(3'b100, 3);
    load_back(3'b001, 2);
    load_back(3'b101, 0);
    load_back(3'b001, 0);
    // sb and sh into 0x980 and 0x984
    for (int off = 0; off < 4; off++) begin
      emit(enc_s(32'h80 + off, 2, 4, 3'b000));
      expect_store(32'h980, 4'b0001 << off, {24'b0, op_a[7:0]} << (8 * off));
    end
    for (int off = 0; off < 4; off += 2) begin
      emit(enc_s(32'h84 + off, 2, 4, 3'b001));
      expect_store(32'h984, 4'b0011 << off, {16'b0, op_a[15:0]} << (8 * off));
    end
    // count to ten with a back branch
    emit(enc_i(0, 0, 3'b000, 6, OPC_OP_IMM));
    emit(enc_i(10, 0, 3'b000, 7, OPC_OP_IMM));
    emit(enc_i(1, 6, 3'b000, 6, OPC_OP_IMM));
    emit(enc_b(-4, 7, 6, 3'b001));
    store_result(6, 32'd10);
    // jal over a store that must never show up
    p = pc_w;
    emit(enc_j(8, 8));
    emit(enc_s(32'h1f0, 0, 4, 3'b010));
    store_result(8, p + 4);
    p = pc_w;
    emit({20'h0, 5'd9, OPC_AUIPC});
    emit(enc_i(12, 9, 3'b000, 10, OPC_JALR));
    emit(enc_s(32'h1f4, 0, 4, 3'b010));
    store_result(10, p + 8);
    emit(enc_b(8, 0, 0, 3'b000));
    emit(enc_s(32'h1f8, 0, 4, 3'b010));
    emit(32'h0010_0073);
  endtask

  task automatic build_fault_program();
    emit(enc_i(1, 0, 3'b000, 1, OPC_OP_IMM));
    emit(enc_i(13, 1, 3'b001, 1, OPC_OP_IMM));
    emit(enc_i(0, 1, 3'b010, 2, OPC_LOAD));
    emit(enc_s(0, 2, 0, 3'b010));
    emit(32'h0010_0073);
  endtask

  task automatic wait_halted(input int max_cycles);
    int n;
    n = 0;
    while (!halted && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!halted) begin
      fail_now("timeout while waiting for the core to halt");
    end
  endtask

  initial rst_q = 1'b1;

  always @(posedge clk) begin : port_checks
    word_t m;
    rst_q <= rst_n_dut;
    if (!rst_n_dut) begin
      first_seen <= 1'b0;
    end
    // reset and its first cycle
    if (!rst_q) begin
      assert (!mem_req && !halted && !fault)
        else fail_now("request or status flag active during reset");
    end
    if (rst_q && rst_n_dut && mem_req && !first_seen) begin
      first_seen <= 1'b1;
      assert (mem_addr == 32'h0 && !mem_we)
        else fail_now($sformatf("MISMATCH mem_addr exp %h got %h", 32'h0, mem_addr));
    end
    if (run_one && rst_q && rst_n_dut) begin
      assert (!fault) else fail_now($sformatf("MISMATCH fault exp %h got %h", 1'b0, fault));
    end
    if (rst_n_dut && mem_req && mem_ack && mem_we) begin
      if (exp_addr.size() == 0) begin
        fail_now($sformatf("store to %h that the program should never make", mem_addr));
      end else begin
        m = strb_mask(exp_strb[0]);
        assert (mem_addr == exp_addr[0])
          else fail_now($sformatf("MISMATCH mem_addr exp %h got %h", exp_addr[0], mem_addr));
        assert (mem_wstrb == exp_strb[0])
          else fail_now($sformatf("MISMATCH mem_wstrb exp %h got %h", exp_strb[0], mem_wstrb));
        assert ((mem_wdata & m) == (exp_data[0] & m))
          else fail_now($sformatf("MISMATCH mem_wdata exp %h got %h",
                                  exp_data[0] & m, mem_wdata & m));
        void'(exp_addr.pop_front());
        void'(exp_strb.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  initial begin
    run_rst_n  = 1'b1;
    run_one    = 1'b1;
    first_seen = 1'b0;
    seed       = 32'h02b5c63b;
    // negative a, positive b and a nonzero shift keep sra/srl and slt/sltu apart
    op_a       = $random(seed) | 32'h8000_0000;
    op_b       = ($random(seed) & 32'h7fff_ffff) | 32'h1;
    fill_memory();
    build_main_program();
    wait_halted(20000);
    assert (!fault) else fail_now($sformatf("MISMATCH fault exp %h got %h", 1'b0, fault));
    repeat (50) begin
      @(negedge clk);
      assert (!mem_req) else fail_now("memory request after EBREAK");
    end
    if (exp_addr.size() != 0) begin
      fail_now($sformatf("%0d expected stores never happened", exp_addr.size()));
    end
    // second run with a load outside memory
    @(posedge clk);
    run_rst_n <= 1'b0;
    run_one   <= 1'b0;
    repeat (4) @(posedge clk);
    fill_memory();
    build_fault_program();
    run_rst_n <= 1'b1;
    wait_halted(2000);
    assert (fault) else fail_now($sformatf("MISMATCH fault exp %h got %h", 1'b1, fault));
    repeat (30) begin
      @(negedge clk);
      assert (!mem_req) else fail_now("memory request after the fault");
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_memory.sv
`default_nettype none

module tb_memory (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req,
  input  logic        we,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic        ack,
  output logic [31:0] rdata,
  output logic        err
);
  timeunit 1ns;
  timeprecision 1ps;

  // 4 KiB, word addressed
  logic [31:0] mem [0:1023];
  int          seed;
  logic        busy;
  logic [1:0]  cnt;
  logic        bad;

  initial begin
    seed  = 32'h02b5c63b;
    ack   = 1'b0;
    err   = 1'b0;
    rdata = '0;
  end

  // everything at or above 0x1000 is outside the model
  assign bad = (addr >= 32'h0000_1000);

  always @(posedge clk) begin
    if (!rst_n) begin
      ack  <= 1'b0;
      err  <= 1'b0;
      busy <= 1'b0;
      cnt  <= 2'd0;
    end else begin
      ack <= 1'b0;
      err <= 1'b0;
      if (req && !ack) begin
        if (!busy) begin
          busy <= 1'b1;
          // 0 to 3 extra wait cycles
          cnt  <= 2'($random(seed));
        end else if (cnt != 2'd0) begin
          cnt <= cnt - 2'd1;
        end else begin
          busy  <= 1'b0;
          ack   <= 1'b1;
          err   <= bad;
          rdata <= bad ? 32'h0 : mem[addr[11:2]];
          if (we && !bad) begin
            for (int i = 0; i < 4; i++) begin
              if (wstrb[i]) begin
                mem[addr[11:2]][8*i +: 8] <= wdata[8*i +: 8];
              end
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held for 4 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- rv_core.sv
`default_nettype none

module rv_core #(
  parameter core_pkg::word_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst_n,
  output logic            mem_req,
  output logic            mem_we,
  output core_pkg::word_t mem_addr,
  output core_pkg::word_t mem_wdata,
  output logic [3:0]      mem_wstrb,
  input  logic            mem_ack,
  input  core_pkg::word_t mem_rdata,
  input  logic            mem_err,
  output logic            halted,
  output logic            fault
);
  import core_pkg::*;

  // fetch side
  logic      if_req;
  logic      if_ack;
  logic      if_err;
  word_t     if_addr;
  word_t     if_rdata;
  word_t     pc;
  word_t     inst;
  logic      inst_valid;
  logic      retire;
  logic      halt_req;
  word_t     next_pc;
  // decode
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_a;
  word_t     alu_b;
  word_t     imm;
  word_t     rs1_val;
  word_t     rs2_val;
  alu_op_t   alu_op;
  mem_size_t mem_size;
  logic [2:0] branch_funct;
  logic      is_branch;
  logic      is_jal;
  logic      is_jalr;
  logic      is_load;
  logic      is_store;
  logic      is_ebreak;
  logic      writes_rd;
  logic      load_unsigned;
  // execute, load/store and write-back
  logic      ls_start;
  logic      ls_done;
  logic      ls_fault;
  logic      any_fault;
  word_t     ex_ls_addr;
  word_t     ex_ls_wdata;
  word_t     load_data;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;
  // load/store bus side
  logic      ls_req;
  logic      ls_we;
  logic      ls_ack;
  logic      ls_err;
  logic [3:0] ls_wstrb;
  word_t     ls_bus_addr;
  word_t     ls_bus_wdata;
  word_t     ls_rdata;

  // fetch errors also latch the fault flag in execute
  assign any_fault = ls_fault | if_err;

  mem_arbiter u_arb (
    .clk(clk), .rst_n(rst_n),
    .if_req(if_req), .if_addr(if_addr), .if_ack(if_ack),
    .if_rdata(if_rdata), .if_err(if_err),
    .ls_req(ls_req), .ls_we(ls_we), .ls_addr(ls_bus_addr),
    .ls_wdata(ls_bus_wdata), .ls_wstrb(ls_wstrb),
    .ls_ack(ls_ack), .ls_rdata(ls_rdata), .ls_err(ls_err),
    .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .mem_err(mem_err)
  );

  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .rst_n(rst_n),
    .retire(retire), .next_pc(next_pc), .halt_req(halt_req),
    .if_req(if_req), .if_addr(if_addr), .if_ack(if_ack),
    .if_rdata(if_rdata), .if_err(if_err),
    .pc(pc), .inst(inst), .inst_valid(inst_valid), .halted(halted)
  );

  reg_file u_rf (
    .clk(clk), .rst_n(rst_n),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
  );

  decode_unit u_dec (
    .pc(pc), .inst(inst),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .imm(imm),
    .rs1_val(rs1_val), .rs2_val(rs2_val), .rd(rd), .branch_funct(branch_funct),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .is_load(is_load), .is_store(is_store), .is_ebreak(is_ebreak),
    .writes_rd(writes_rd), .mem_size(mem_size), .load_unsigned(load_unsigned)
  );

  exec_unit u_exec (
    .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid),
    .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .imm(imm),
    .rs1_val(rs1_val), .rs2_val(rs2_val), .rd(rd), .branch_funct(branch_funct),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .is_load(is_load), .is_store(is_store), .is_ebreak(is_ebreak),
    .writes_rd(writes_rd), .pc(pc),
    .ls_start(ls_start), .ls_addr(ex_ls_addr), .ls_wdata(ex_ls_wdata),
    .ls_done(ls_done), .load_data(load_data), .ls_fault(any_fault),
    .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
    .retire(retire), .next_pc(next_pc), .halt_req(halt_req), .fault(fault)
  );

  load_store_unit u_lsu (
    .clk(clk), .rst_n(rst_n),
    .ls_start(ls_start), .ls_addr(ex_ls_addr), .ls_wdata(ex_ls_wdata),
    .is_store(is_store), .mem_size(mem_size), .load_unsigned(load_unsigned),
    .ls_req(ls_req), .ls_we(ls_we), .ls_bus_addr(ls_bus_addr),
    .ls_bus_wdata(ls_bus_wdata), .ls_wstrb(ls_wstrb),
    .ls_ack(ls_ack), .ls_rdata(ls_rdata), .ls_err(ls_err),
    .ls_done(ls_done), .load_data(load_data), .ls_fault(ls_fault)
  );

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`default_nettype none

module mem_arbiter (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            if_req,
  input  core_pkg::word_t if_addr,
  output logic            if_ack,
  output core_pkg::word_t if_rdata,
  output logic            if_err,
  input  logic            ls_req,
  input  logic            ls_we,
  input  core_pkg::word_t ls_addr,
  input  core_pkg::word_t ls_wdata,
  input  logic [3:0]      ls_wstrb,
  output logic            ls_ack,
  output core_pkg::word_t ls_rdata,
  output logic            ls_err,
  output logic            mem_req,
  output logic            mem_we,
  output core_pkg::word_t mem_addr,
  output core_pkg::word_t mem_wdata,
  output logic [3:0]      mem_wstrb,
  input  logic            mem_ack,
  input  core_pkg::word_t mem_rdata,
  input  logic            mem_err
);
  typedef enum logic {S_IDLE, S_BUSY} state_e;

  state_e state;
  logic   owner_ls_q;
  logic   sel_ls;

  // load/store first when idle, then locked to the owner until ack
  assign sel_ls = (state == S_BUSY) ? owner_ls_q : ls_req;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      owner_ls_q <= 1'b0;
    end else if (state == S_IDLE) begin
      if (mem_req && !mem_ack) begin
        state      <= S_BUSY;
        owner_ls_q <= sel_ls;
      end
    end else if (mem_ack) begin
      state <= S_IDLE;
    end
  end

  assign mem_req   = sel_ls ? ls_req : if_req;
  assign mem_we    = sel_ls & ls_we;
  assign mem_addr  = sel_ls ? ls_addr : if_addr;
  assign mem_wdata = sel_ls ? ls_wdata : '0;
  assign mem_wstrb = sel_ls ? ls_wstrb : 4'b0000;

  assign if_ack   = mem_ack & ~sel_ls;
  assign ls_ack   = mem_ack & sel_ls;
  assign if_err   = mem_err & if_ack;
  assign ls_err   = mem_err & ls_ack;
  assign if_rdata = mem_rdata;
  assign ls_rdata = mem_rdata;

endmodule

`default_nettype wire

//--- load_store_unit.sv
`default_nettype none

module load_store_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ls_start,
  input  core_pkg::word_t     ls_addr,
  input  core_pkg::word_t     ls_wdata,
  input  logic                is_store,
  input  core_pkg::mem_size_t mem_size,
  input  logic                load_unsigned,
  output logic                ls_req,
  output logic                ls_we,
  output core_pkg::word_t     ls_bus_addr,
  output core_pkg::word_t     ls_bus_wdata,
  output logic [3:0]          ls_wstrb,
  input  logic                ls_ack,
  input  core_pkg::word_t     ls_rdata,
  input  logic                ls_err,
  output logic                ls_done,
  output core_pkg::word_t     load_data,
  output logic                ls_fault
);
  import core_pkg::*;

  // address, data and size come straight from decode/execute,
  // which hold them until retire
  logic [1:0] off;
  logic [3:0] strb;
  word_t      rdata_q;
  word_t      lane;

  assign off = ls_addr[1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ls_req   <= 1'b0;
      ls_done  <= 1'b0;
      ls_fault <= 1'b0;
    end else begin
      if (ls_start) begin
        ls_req <= 1'b1;
      end else if (ls_ack) begin
        ls_req <= 1'b0;
      end
      ls_done  <= ls_req & ls_ack & ~ls_err;
      ls_fault <= ls_req & ls_ack & ls_err;
    end
  end

  always_ff @(posedge clk) begin
    if (ls_req && ls_ack) begin
      rdata_q <= ls_rdata;
    end
  end

  always_comb begin
    case (mem_size)
      SIZE_BYTE: begin
        strb         = 4'b0001 << off;
        ls_bus_wdata = {4{ls_wdata[7:0]}};
      end
      SIZE_HALF: begin
        strb         = 4'b0011 << {off[1], 1'b0};
        ls_bus_wdata = {2{ls_wdata[15:0]}};
      end
      default: begin
        strb         = 4'b1111;
        ls_bus_wdata = ls_wdata;
      end
    endcase
  end

  assign ls_we       = is_store;
  assign ls_wstrb    = is_store ? strb : 4'b0000;
  assign ls_bus_addr = {ls_addr[31:2], 2'b00};

  // move the addressed lane down to bit 0
  assign lane = rdata_q >> {off, 3'b000};

  always_comb begin
    case (mem_size)
      SIZE_BYTE: load_data = {{24{lane[7] & ~load_unsigned}}, lane[7:0]};
      SIZE_HALF: load_data = {{16{lane[15] & ~load_unsigned}}, lane[15:0]};
      default:   load_data = lane;
    endcase
  end

endmodule

`default_nettype wire

//--- exec_unit.sv
`default_nettype none

module exec_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                inst_valid,
  input  core_pkg::word_t     alu_a,
  input  core_pkg::word_t     alu_b,
  input  core_pkg::alu_op_t   alu_op,
  input  core_pkg::word_t     imm,
  input  core_pkg::word_t     rs1_val,
  input  core_pkg::word_t     rs2_val,
  input  core_pkg::reg_addr_t rd,
  input  logic [2:0]          branch_funct,
  input  logic                is_branch,
  input  logic                is_jal,
  input  logic                is_jalr,
  input  logic                is_load,
  input  logic                is_store,
  input  logic                is_ebreak,
  input  logic                writes_rd,
  input  core_pkg::word_t     pc,
  output logic                ls_start,
  output core_pkg::word_t     ls_addr,
  output core_pkg::word_t     ls_wdata,
  input  logic                ls_done,
  input  core_pkg::word_t     load_data,
  input  logic                ls_fault,
  output logic                rf_we,
  output core_pkg::reg_addr_t rf_waddr,
  output core_pkg::word_t     rf_wdata,
  output logic                retire,
  output core_pkg::word_t     next_pc,
  output logic                halt_req,
  output logic                fault
);
  import core_pkg::*;

  typedef enum logic {S_IDLE, S_MEM} state_e;

  state_e state;
  word_t  alu_y;
  word_t  pc_plus4;
  logic   cmp;
  logic   taken;
  logic   active;
  logic   is_mem;

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_y = alu_a + alu_b;
      ALU_SUB:    alu_y = alu_a - alu_b;
      ALU_SLL:    alu_y = alu_a << alu_b[4:0];
      ALU_SLT:    alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU:   alu_y = {31'b0, alu_a < alu_b};
      ALU_XOR:    alu_y = alu_a ^ alu_b;
      ALU_SRL:    alu_y = alu_a >> alu_b[4:0];
      ALU_SRA:    alu_y = $signed(alu_a) >>> alu_b[4:0];
      ALU_OR:     alu_y = alu_a | alu_b;
      ALU_AND:    alu_y = alu_a & alu_b;
      ALU_PASS_B: alu_y = alu_b;
      default:    alu_y = alu_a + alu_b;
    endcase
  end

  // funct3[2:1] picks eq/lt/ltu, funct3[0] inverts
  always_comb begin
    case (branch_funct[2:1])
      2'b10:   cmp = $signed(rs1_val) < $signed(rs2_val);
      2'b11:   cmp = rs1_val < rs2_val;
      default: cmp = (rs1_val == rs2_val);
    endcase
  end

  assign taken    = is_branch & (cmp ^ branch_funct[0]);
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    if (is_jal) begin
      next_pc = alu_y;
    end else if (is_jalr) begin
      next_pc = {alu_y[31:1], 1'b0};
    end else if (taken) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  assign active = inst_valid & ~fault;
  assign is_mem = is_load | is_store;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      fault <= 1'b0;
    end else begin
      if (ls_fault) begin
        fault <= 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (active && is_mem) begin
            state <= S_MEM;
          end
        end
        default: begin
          if (ls_done || ls_fault) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  assign ls_start = (state == S_IDLE) & active & is_mem;
  assign ls_addr  = alu_y;
  assign ls_wdata = rs2_val;

  // a faulting access neither retires nor writes
  assign retire = (state == S_IDLE) ? (active & ~is_mem) : (ls_done & ~ls_fault);
  assign rf_we  = writes_rd & retire;

  assign rf_waddr = rd;
  assign rf_wdata = is_load ? load_data : ((is_jal | is_jalr) ? pc_plus4 : alu_y);

  assign halt_req = fault | ls_fault | (inst_valid & is_ebreak);

endmodule

`default_nettype wire

//--- decode_unit.sv
`default_nettype none

module decode_unit (
  input  core_pkg::word_t     pc,
  input  core_pkg::word_t     inst,
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  input  core_pkg::word_t     rs1_data,
  input  core_pkg::word_t     rs2_data,
  output core_pkg::word_t     alu_a,
  output core_pkg::word_t     alu_b,
  output core_pkg::alu_op_t   alu_op,
  output core_pkg::word_t     imm,
  output core_pkg::word_t     rs1_val,
  output core_pkg::word_t     rs2_val,
  output core_pkg::reg_addr_t rd,
  output logic [2:0]          branch_funct,
  output logic                is_branch,
  output logic                is_jal,
  output logic                is_jalr,
  output logic                is_load,
  output logic                is_store,
  output logic                is_ebreak,
  output logic                writes_rd,
  output core_pkg::mem_size_t mem_size,
  output logic                load_unsigned
);
  import core_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign rs1_addr      = inst[19:15];
  assign rs2_addr      = inst[24:20];
  assign rs1_val       = rs1_data;
  assign rs2_val       = rs2_data;
  assign rd            = inst[11:7];
  assign branch_funct  = funct3;
  assign mem_size      = funct3[1:0];
  assign load_unsigned = funct3[2];

  always_comb begin
    // unknown opcodes fall through as a no-op
    alu_a     = rs1_data;
    alu_b     = imm_i;
    alu_op    = ALU_ADD;
    imm       = imm_i;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_ebreak = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      OPC_LUI: begin
        alu_a     = '0;
        alu_b     = imm_u;
        alu_op    = ALU_PASS_B;
        writes_rd = 1'b1;
      end
      OPC_AUIPC: begin
        alu_a     = pc;
        alu_b     = imm_u;
        writes_rd = 1'b1;
      end
      OPC_JAL: begin
        alu_a     = pc;
        alu_b     = imm_j;
        imm       = imm_j;
        is_jal    = 1'b1;
        writes_rd = 1'b1;
      end
      OPC_JALR: begin
        is_jalr   = 1'b1;
        writes_rd = 1'b1;
      end
      OPC_BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
      end
      OPC_LOAD: begin
        is_load   = 1'b1;
        writes_rd = 1'b1;
      end
      OPC_STORE: begin
        alu_b    = imm_s;
        imm      = imm_s;
        is_store = 1'b1;
      end
      OPC_OP_IMM: begin
        // only shifts look at bit 30, addi must never become sub
        alu_op    = (funct3 == 3'b101) ? {inst[30], funct3} : {1'b0, funct3};
        writes_rd = 1'b1;
      end
      OPC_OP: begin
        alu_b     = rs2_data;
        alu_op    = {inst[30], funct3};
        writes_rd = 1'b1;
      end
      OPC_SYSTEM: is_ebreak = (inst == 32'h0010_0073);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- fetch_unit.sv
`default_nettype none

module fetch_unit #(
  parameter core_pkg::word_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            retire,
  input  core_pkg::word_t next_pc,
  input  logic            halt_req,
  output logic            if_req,
  output core_pkg::word_t if_addr,
  input  logic            if_ack,
  input  core_pkg::word_t if_rdata,
  input  logic            if_err,
  output core_pkg::word_t pc,
  output core_pkg::word_t inst,
  output logic            inst_valid,
  output logic            halted
);
  import core_pkg::*;

  // S_IDLE only covers the first cycle out of reset
  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_STOP} state_e;

  state_e state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      pc    <= RESET_PC;
    end else begin
      case (state)
        S_IDLE: state <= S_REQ;
        S_REQ: begin
          if (if_ack) begin
            state <= if_err ? S_STOP : S_WAIT;
          end
        end
        S_WAIT: begin
          // halt wins over retire, ebreak retires and stops here
          if (halt_req) begin
            state <= S_STOP;
          end else if (retire) begin
            state <= S_REQ;
            pc    <= next_pc;
          end
        end
        default: state <= S_STOP;
      endcase
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (state == S_REQ && if_ack) begin
      inst <= if_rdata;
    end
  end

  assign if_req     = (state == S_REQ);
  assign if_addr    = pc;
  assign inst_valid = (state == S_WAIT);
  assign halted     = (state == S_STOP);

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file (
  input  logic               clk,
  input  logic               rst_n,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  output core_pkg::word_t    rs1_data,
  output core_pkg::word_t    rs2_data,
  input  logic               we,
  input  core_pkg::reg_addr_t waddr,
  input  core_pkg::word_t    wdata
);
  import core_pkg::*;

  // x1..x31 only, x0 has no storage
  word_t regs [31:1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [1:0]  mem_size_t;
  typedef logic [6:0]  opcode_t;

  // bit 3 mirrors funct7[5] so OP decodes as {inst[30], funct3}
  localparam alu_op_t ALU_ADD    = 4'b0000;
  localparam alu_op_t ALU_SLL    = 4'b0001;
  localparam alu_op_t ALU_SLT    = 4'b0010;
  localparam alu_op_t ALU_SLTU   = 4'b0011;
  localparam alu_op_t ALU_XOR    = 4'b0100;
  localparam alu_op_t ALU_SRL    = 4'b0101;
  localparam alu_op_t ALU_OR     = 4'b0110;
  localparam alu_op_t ALU_AND    = 4'b0111;
  localparam alu_op_t ALU_SUB    = 4'b1000;
  localparam alu_op_t ALU_SRA    = 4'b1101;
  localparam alu_op_t ALU_PASS_B = 4'b1111;

  // same encoding as funct3[1:0] of loads and stores
  localparam mem_size_t SIZE_BYTE = 2'b00;
  localparam mem_size_t SIZE_HALF = 2'b01;
  localparam mem_size_t SIZE_WORD = 2'b10;

  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire
